/* flist.f */
hw/mipsIsaPkg.sv
hw/coreBusPkg.sv
hw/coreIfs.sv
hw/regFile.sv
hw/alu.sv
hw/instrDecoder.sv
hw/fetchUnit.sv
hw/executeStage.sv
hw/memAccessUnit.sv
hw/mipsCore.sv
sim/tbMipsCore.sv

/* sim/tbMipsCore.sv */
`timescale 1ns/1ns

module tbMipsCore;

    localparam coreBusPkg::addrT resetPc = 32'h0000_1000;
    // Last program word jumps to itself
    localparam coreBusPkg::addrT haltAddr = resetPc + 32'd252;

    typedef struct packed {
        coreBusPkg::addrT addr;
        logic we;
        coreBusPkg::selT sel;
        coreBusPkg::wordT wdata;
    } dataAccT;

    logic clk = 1'b0;
    logic rstN;
    coreBusPkg::addrT iwbAdr;
    coreBusPkg::wordT iwbDatI = '0;
    logic iwbCyc;
    logic iwbStb;
    logic iwbAck = 1'b0;
    coreBusPkg::addrT dwbAdr;
    coreBusPkg::wordT dwbDatO;
    coreBusPkg::wordT dwbDatI = '0;
    coreBusPkg::selT dwbSel;
    logic dwbWe;
    logic dwbCyc;
    logic dwbStb;
    logic dwbAck = 1'b0;

    coreBusPkg::wordT prog [64];
    coreBusPkg::wordT modelMem [256];
    coreBusPkg::wordT busMem [256];
    logic targeted [64];
    coreBusPkg::addrT fetchQ [$];
    dataAccT dataQ [$];
    int modelSteps;
    logic modelDone = 1'b0;
    logic haltSeen = 1'b0;

    logic iActive = 1'b0;
    int iWait;
    coreBusPkg::addrT iAdrSeen;
    logic dActive = 1'b0;
    int dWait;
    coreBusPkg::addrT dAdrSeen;
    coreBusPkg::wordT dDatSeen;
    coreBusPkg::selT dSelSeen;

    mipsCore #(
        .resetPc(resetPc)
    ) uut (
        .clk(clk),
        .rstN(rstN),
        .iwbAdr(iwbAdr),
        .iwbDatI(iwbDatI),
        .iwbCyc(iwbCyc),
        .iwbStb(iwbStb),
        .iwbAck(iwbAck),
        .dwbAdr(dwbAdr),
        .dwbDatO(dwbDatO),
        .dwbDatI(dwbDatI),
        .dwbSel(dwbSel),
        .dwbWe(dwbWe),
        .dwbCyc(dwbCyc),
        .dwbStb(dwbStb),
        .dwbAck(dwbAck)
    );

    always #5 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic checkAddr(input string name, input coreBusPkg::addrT expected,
            input coreBusPkg::addrT actual);
        if (actual !== expected)
            abortRun($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic checkWord(input string name, input coreBusPkg::wordT expected,
            input coreBusPkg::wordT actual);
        if (actual !== expected)
            abortRun($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic checkSel(input string name, input coreBusPkg::selT expected,
            input coreBusPkg::selT actual);
        if (actual !== expected)
            abortRun($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abortRun($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
    endtask

    function automatic coreBusPkg::wordT rTypeWord(logic [5:0] fn, logic [4:0] rs,
            logic [4:0] rt, logic [4:0] rd, logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic coreBusPkg::wordT immWord(logic [5:0] op, logic [4:0] rs,
            logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic coreBusPkg::wordT jumpWord(logic [5:0] op, coreBusPkg::addrT target);
        return {op, target[27:2]};
    endfunction

    // Offsets from r29 = 0x100 covering data memory 0x000 to 0x3ff
    function automatic logic [15:0] wordOffset();
        return 16'(-256 + 4 * ($urandom % 256));
    endfunction

    function automatic logic [15:0] byteOffset();
        return 16'(-256 + ($urandom % 1024));
    endfunction

    // Scratch region 0x200 to 0x3fc
    function automatic logic [15:0] scratchOffset();
        return 16'(256 + 4 * ($urandom % 128));
    endfunction

    function automatic coreBusPkg::addrT slotAddr(int slot);
        return resetPc + 32'(4 * slot);
    endfunction

    task automatic fillMemory();
        coreBusPkg::wordT w;
        for (int k = 0; k < 256; k++) begin
            w = $urandom;
            modelMem[k] = w;
            busMem[k] = w;
        end
    endtask

    task automatic buildProgram();
        int i;
        int kind;
        int span;
        int tgt;
        logic [4:0] d;
        logic [4:0] s;
        logic [4:0] r;
        for (int k = 0; k < 64; k++)
            targeted[k] = 1'b0;
        prog[0] = immWord(mipsIsaPkg::opOri, 5'd0, 5'd29, 16'h0100);
        i = 1;
        while (i < 63) begin
            kind = $urandom % 10;
            d = 5'($urandom % 8);
            s = 5'($urandom % 8);
            r = 5'($urandom % 8);
            span = (kind <= 4 || kind == 8) ? 2 : ((kind == 7) ? 3 : 1);
            // Never land a branch on a jr whose ori was skipped
            if (i + span > 63 || (kind == 8 && targeted[i + 1])) begin
                kind = 5;
                span = 1;
            end
            case (kind)
                0, 1, 2, 3: begin
                    case ($urandom % 12)
                        0: prog[i] = rTypeWord(mipsIsaPkg::fnAddu, s, r, d, 5'd0);
                        1: prog[i] = rTypeWord(mipsIsaPkg::fnSubu, s, r, d, 5'd0);
                        2: prog[i] = rTypeWord(mipsIsaPkg::fnAnd, s, r, d, 5'd0);
                        3: prog[i] = rTypeWord(mipsIsaPkg::fnOr, s, r, d, 5'd0);
                        4: prog[i] = rTypeWord(mipsIsaPkg::fnXor, s, r, d, 5'd0);
                        5: prog[i] = rTypeWord(mipsIsaPkg::fnSlt, s, r, d, 5'd0);
                        6: prog[i] = rTypeWord(mipsIsaPkg::fnSll, 5'd0, r, d, 5'($urandom));
                        7: prog[i] = immWord(mipsIsaPkg::opAddiu, s, d, 16'($urandom));
                        8: prog[i] = immWord(mipsIsaPkg::opAndi, s, d, 16'($urandom));
                        9: prog[i] = immWord(mipsIsaPkg::opOri, s, d, 16'($urandom));
                        10: prog[i] = immWord(mipsIsaPkg::opSlti, s, d, 16'($urandom));
                        default: prog[i] = immWord(mipsIsaPkg::opLui, 5'd0, d, 16'($urandom));
                    endcase
                    prog[i + 1] = immWord(mipsIsaPkg::opSw, 5'd29, d, scratchOffset());
                end
                4: begin
                    if ($urandom % 2)
                        prog[i] = immWord(mipsIsaPkg::opLw, 5'd29, d, wordOffset());
                    else
                        prog[i] = immWord(mipsIsaPkg::opLb, 5'd29, d, byteOffset());
                    prog[i + 1] = immWord(mipsIsaPkg::opSw, 5'd29, d, scratchOffset());
                end
                5: begin
                    if ($urandom % 2)
                        prog[i] = immWord(mipsIsaPkg::opSw, 5'd29, r, wordOffset());
                    else
                        prog[i] = immWord(mipsIsaPkg::opSb, 5'd29, r, byteOffset());
                end
                6: begin
                    tgt = i + 1 + $urandom % 4;
                    if (tgt > 63)
                        tgt = 63;
                    targeted[tgt] = 1'b1;
                    if ($urandom % 2)
                        prog[i] = immWord(mipsIsaPkg::opBeq, s, r, 16'(tgt - i - 1));
                    else
                        prog[i] = immWord(mipsIsaPkg::opBne, s, r, 16'(tgt - i - 1));
                end
                7: begin
                    // Link value is stored at the jal target
                    prog[i] = jumpWord(mipsIsaPkg::opJal, slotAddr(i + 2));
                    prog[i + 1] = immWord(mipsIsaPkg::opSw, 5'd29, r, scratchOffset());
                    prog[i + 2] = immWord(mipsIsaPkg::opSw, 5'd29, 5'd31, scratchOffset());
                    targeted[i + 2] = 1'b1;
                end
                8: begin
                    tgt = i + 2 + $urandom % 4;
                    if (tgt > 63)
                        tgt = 63;
                    targeted[tgt] = 1'b1;
                    prog[i] = immWord(mipsIsaPkg::opOri, 5'd0, 5'd30, 16'(slotAddr(tgt)));
                    prog[i + 1] = rTypeWord(mipsIsaPkg::fnJr, 5'd30, 5'd0, 5'd0, 5'd0);
                end
                default: begin
                    if ($urandom % 2) begin
                        tgt = i + 1 + $urandom % 4;
                        if (tgt > 63)
                            tgt = 63;
                        targeted[tgt] = 1'b1;
                        prog[i] = jumpWord(mipsIsaPkg::opJ, slotAddr(tgt));
                    end else begin
                        // Opcode outside the subset
                        prog[i] = {6'h3f, 26'($urandom)};
                    end
                end
            endcase
            i += span;
        end
        prog[63] = jumpWord(mipsIsaPkg::opJ, haltAddr);
    endtask

    function automatic void recordAccess(coreBusPkg::addrT addr, logic we,
            coreBusPkg::selT sel, coreBusPkg::wordT wdata);
        dataAccT acc;
        acc.addr = addr;
        acc.we = we;
        acc.sel = sel;
        acc.wdata = wdata;
        dataQ.push_back(acc);
    endfunction

    // Instruction-set model without delay slots
    task automatic runModel();
        coreBusPkg::wordT regs [32];
        coreBusPkg::addrT pc;
        coreBusPkg::addrT nextPc;
        coreBusPkg::addrT ea;
        coreBusPkg::wordT ins;
        coreBusPkg::wordT a;
        coreBusPkg::wordT b;
        coreBusPkg::wordT se;
        coreBusPkg::wordT ze;
        coreBusPkg::wordT res;
        logic [4:0] dst;
        logic wr;
        logic [7:0] bt;
        for (int k = 0; k < 32; k++)
            regs[k] = '0;
        pc = resetPc;
        modelSteps = 0;
        fetchQ.push_back(pc);
        while (pc != haltAddr) begin
            ins = prog[6'((pc - resetPc) >> 2)];
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            se = {{16{ins[15]}}, ins[15:0]};
            ze = {16'h0000, ins[15:0]};
            ea = a + se;
            nextPc = pc + 32'd4;
            dst = ins[20:16];
            wr = 1'b1;
            res = '0;
            case (ins[31:26])
                mipsIsaPkg::opRtype: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        mipsIsaPkg::fnAddu: res = a + b;
                        mipsIsaPkg::fnSubu: res = a - b;
                        mipsIsaPkg::fnAnd: res = a & b;
                        mipsIsaPkg::fnOr: res = a | b;
                        mipsIsaPkg::fnXor: res = a ^ b;
                        mipsIsaPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        mipsIsaPkg::fnSll: res = b << ins[10:6];
                        mipsIsaPkg::fnJr: begin
                            wr = 1'b0;
                            nextPc = a;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                mipsIsaPkg::opAddiu: res = a + se;
                mipsIsaPkg::opAndi: res = a & ze;
                mipsIsaPkg::opOri: res = a | ze;
                mipsIsaPkg::opSlti: res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
                mipsIsaPkg::opLui: res = {ins[15:0], 16'h0000};
                mipsIsaPkg::opLw: begin
                    res = modelMem[ea[9:2]];
                    recordAccess({ea[31:2], 2'b00}, 1'b0, 4'hf, '0);
                end
                mipsIsaPkg::opLb: begin
                    bt = modelMem[ea[9:2]][8 * ea[1:0] +: 8];
                    res = {{24{bt[7]}}, bt};
                    recordAccess(ea, 1'b0, 4'b0001 << ea[1:0], '0);
                end
                mipsIsaPkg::opSw: begin
                    wr = 1'b0;
                    modelMem[ea[9:2]] = b;
                    recordAccess({ea[31:2], 2'b00}, 1'b1, 4'hf, b);
                end
                mipsIsaPkg::opSb: begin
                    wr = 1'b0;
                    modelMem[ea[9:2]][8 * ea[1:0] +: 8] = b[7:0];
                    recordAccess(ea, 1'b1, 4'b0001 << ea[1:0], {4{b[7:0]}});
                end
                mipsIsaPkg::opBeq, mipsIsaPkg::opBne: begin
                    wr = 1'b0;
                    if ((a == b) == (ins[31:26] == mipsIsaPkg::opBeq))
                        nextPc = pc + 32'd4 + (se << 2);
                end
                mipsIsaPkg::opJ, mipsIsaPkg::opJal: begin
                    wr = (ins[31:26] == mipsIsaPkg::opJal);
                    dst = 5'd31;
                    res = pc + 32'd4;
                    nextPc = {nextPc[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0)
                regs[dst] = res;
            pc = nextPc;
            modelSteps++;
            if (modelSteps > 1000)
                abortRun("The model never reached the halt loop");
            fetchQ.push_back(pc);
        end
        modelSteps++;
    endtask

    task automatic matchFetch(input coreBusPkg::addrT adr);
        if (fetchQ.size() > 0)
            checkAddr("fetch address", fetchQ.pop_front(), adr);
        else if (adr != haltAddr)
            abortRun("The core fetched past the end of the model's instruction trace");
        else
            haltSeen = 1'b1;
    endtask

    task automatic matchAccess();
        dataAccT exp;
        if (dataQ.size() == 0) begin
            abortRun("The core made a data access that the model does not expect");
        end else begin
            exp = dataQ.pop_front();
            checkAddr("data address", exp.addr, dwbAdr);
            checkBit("data write enable", exp.we, dwbWe);
            checkSel("data byte select", exp.sel, dwbSel);
            if (exp.we)
                checkWord("store data", exp.wdata, dwbDatO);
            dAdrSeen = dwbAdr;
            dDatSeen = dwbDatO;
            dSelSeen = dwbSel;
        end
    endtask

    // Instruction memory slave with 0 to 3 wait states
    always @(posedge clk) begin
        if (!rstN) begin
            if (iwbCyc !== 1'b0 || iwbStb !== 1'b0 || dwbCyc !== 1'b0 ||
                    dwbStb !== 1'b0 || dwbWe !== 1'b0)
                abortRun("A bus signal was active while reset was asserted");
            iwbAck <= 1'b0;
        end else if (iwbAck) begin
            iwbAck <= 1'b0;
        end else if (iwbCyc && iwbStb) begin
            if (!iActive) begin
                iActive = 1'b1;
                iWait = $urandom % 4;
                iAdrSeen = iwbAdr;
                matchFetch(iwbAdr);
            end
            if (iWait == 0) begin
                checkAddr("fetch address held", iAdrSeen, iwbAdr);
                iwbDatI <= prog[6'((iwbAdr - resetPc) >> 2)];
                iwbAck <= 1'b1;
                iActive = 1'b0;
            end else begin
                iWait--;
            end
        end
    end

    // Data memory slave with byte lanes on writes
    always @(posedge clk) begin
        if (!rstN) begin
            dwbAck <= 1'b0;
        end else if (dwbAck) begin
            dwbAck <= 1'b0;
        end else if (dwbCyc && dwbStb) begin
            if (!dActive) begin
                dActive = 1'b1;
                dWait = $urandom % 4;
                matchAccess();
            end
            if (dWait == 0) begin
                checkAddr("data address held", dAdrSeen, dwbAdr);
                checkWord("data out held", dDatSeen, dwbDatO);
                checkSel("byte select held", dSelSeen, dwbSel);
                if (dwbWe) begin
                    for (int k = 0; k < 4; k++) begin
                        if (dwbSel[k])
                            busMem[dwbAdr[9:2]][8 * k +: 8] = dwbDatO[8 * k +: 8];
                    end
                end else begin
                    dwbDatI <= busMem[dwbAdr[9:2]];
                end
                dwbAck <= 1'b1;
                dActive = 1'b0;
            end else begin
                dWait--;
            end
        end
    end

    initial begin
        int limitNs;
        wait (modelDone);
        // Up to 12 cycles per instruction at full wait states plus reset
        limitNs = (modelSteps + 16) * 12 * 10;
        #(limitNs);
        abortRun("Timeout: the core did not reach the halt loop in time");
    end

    initial begin
        rstN <= 1'b0;
        void'($urandom(32'h5db7));
        fillMemory();
        buildProgram();
        runModel();
        modelDone = 1'b1;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        wait (haltSeen);
        if (dataQ.size() != 0) begin
            abortRun("The core halted with data accesses of the model still outstanding");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

/* hw/mipsCore.sv */
`timescale 1ns/1ns

module mipsCore #(
    parameter coreBusPkg::addrT resetPc = 32'h0000_0000
) (
    input  logic clk,
    input  logic rstN,
    // Instruction bus
    output coreBusPkg::addrT iwbAdr,
    input  coreBusPkg::wordT iwbDatI,
    output logic iwbCyc,
    output logic iwbStb,
    input  logic iwbAck,
    // Data bus
    output coreBusPkg::addrT dwbAdr,
    output coreBusPkg::wordT dwbDatO,
    input  coreBusPkg::wordT dwbDatI,
    output coreBusPkg::selT dwbSel,
    output logic dwbWe,
    output logic dwbCyc,
    output logic dwbStb,
    input  logic dwbAck
);

    fetchIf fetchBus ();
    memReqIf memBus ();

    fetchUnit #(
        .resetPc(resetPc)
    ) fetcher (
        .clk(clk),
        .rstN(rstN),
        .fetch(fetchBus.fetch),
        .iwbAdr(iwbAdr),
        .iwbDatI(iwbDatI),
        .iwbCyc(iwbCyc),
        .iwbStb(iwbStb),
        .iwbAck(iwbAck)
    );

    executeStage exec (
        .clk(clk),
        .rstN(rstN),
        .fetch(fetchBus.exec),
        .mem(memBus.req)
    );

    memAccessUnit memUnit (
        .clk(clk),
        .rstN(rstN),
        .mem(memBus.rsp),
        .dwbAdr(dwbAdr),
        .dwbDatO(dwbDatO),
        .dwbDatI(dwbDatI),
        .dwbSel(dwbSel),
        .dwbWe(dwbWe),
        .dwbCyc(dwbCyc),
        .dwbStb(dwbStb),
        .dwbAck(dwbAck)
    );

endmodule

/* hw/memAccessUnit.sv */
`timescale 1ns/1ns

module memAccessUnit (
    input  logic clk,
    input  logic rstN,
    memReqIf.rsp mem,
    output coreBusPkg::addrT dwbAdr,
    output coreBusPkg::wordT dwbDatO,
    input  coreBusPkg::wordT dwbDatI,
    output coreBusPkg::selT dwbSel,
    output logic dwbWe,
    output logic dwbCyc,
    output logic dwbStb,
    input  logic dwbAck
);
    logic busy;
    logic doneQ;
    logic isWord;
    logic [7:0] loadByte;
    coreBusPkg::wordT loadData;
    coreBusPkg::wordT rdataQ;

    assign isWord = (mem.size == coreBusPkg::sizeWord);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            doneQ <= 1'b0;
        end else begin
            // No restart in the done cycle while the request is still up
            if (!busy && !doneQ && mem.reqValid)
                busy <= 1'b1;
            else if (busy && dwbAck)
                busy <= 1'b0;
            doneQ <= busy && dwbAck;
        end
    end

    always_ff @(posedge clk) begin
        if (busy && dwbAck)
            rdataQ <= loadData;
    end

    // Little-endian lanes
    assign dwbAdr = isWord ? {mem.addr[31:2], 2'b00} : mem.addr;
    assign dwbSel = isWord ? 4'b1111 : (4'b0001 << mem.addr[1:0]);
    assign dwbDatO = isWord ? mem.wdata : {4{mem.wdata[7:0]}};
    assign dwbWe = busy && mem.we;
    assign dwbCyc = busy;
    assign dwbStb = busy;

    always_comb begin
        case (mem.addr[1:0])
            2'd0: loadByte = dwbDatI[7:0];
            2'd1: loadByte = dwbDatI[15:8];
            2'd2: loadByte = dwbDatI[23:16];
            default: loadByte = dwbDatI[31:24];
        endcase
        if (isWord)
            loadData = dwbDatI;
        else if (mem.signedLoad)
            loadData = {{24{loadByte[7]}}, loadByte};
        else
            loadData = {24'h000000, loadByte};
    end

    assign mem.done = doneQ;
    assign mem.rdata = rdataQ;

    // Classic cycle ends in the cycle after ack
    assert property (@(posedge clk) disable iff (!rstN) dwbCyc && dwbAck |=> !dwbCyc);

    // Execute must hold the request through wait states
    assert property (@(posedge clk) disable iff (!rstN)
        dwbStb && !dwbAck |=> $stable(dwbAdr) && $stable(dwbDatO) && $stable(dwbSel));

    assert property (@(posedge clk) disable iff (!rstN)
        mem.reqValid && isWord |-> mem.addr[1:0] == 2'b00);

endmodule

/* hw/executeStage.sv */
`timescale 1ns/1ns

module executeStage (
    input  logic clk,
    input  logic rstN,
    fetchIf.exec fetch,
    memReqIf.req mem
);
    typedef enum logic {execute, waitMem} execStateE;

    execStateE state;
    mipsIsaPkg::regIdxT rs;
    mipsIsaPkg::regIdxT rt;
    mipsIsaPkg::regIdxT writeReg;
    mipsIsaPkg::aluOpE aluOp;
    coreBusPkg::memSizeE size;
    coreBusPkg::wordT imm;
    coreBusPkg::wordT da;
    coreBusPkg::wordT db;
    coreBusPkg::wordT aluB;
    coreBusPkg::wordT aluResult;
    coreBusPkg::wordT wbData;
    coreBusPkg::addrT pcPlus4;
    coreBusPkg::addrT branchTarget;
    coreBusPkg::addrT jumpTarget;
    logic [25:0] jumpIndex;
    logic aluSrcImm, regWrite, memRead, memWrite;
    logic branch, branchNe, jump, link, jumpReg;
    logic zero, takeBranch, isMem;

    instrDecoder decoder (
        .instr(fetch.instr), .rs(rs), .rt(rt), .writeReg(writeReg), .imm(imm),
        .jumpIndex(jumpIndex), .aluOp(aluOp), .aluSrcImm(aluSrcImm),
        .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
        .branch(branch), .branchNe(branchNe), .jump(jump), .link(link),
        .jumpReg(jumpReg), .size(size)
    );

    regFile regs (
        .clk(clk), .rstN(rstN), .ra(rs), .rb(rt), .rw(writeReg),
        .we(regWrite && fetch.done), .wd(wbData), .da(da), .db(db)
    );

    assign aluB = aluSrcImm ? imm : db;

    alu alu0 (
        .a(da), .b(aluB), .shamt(fetch.instr[10:6]), .op(aluOp),
        .result(aluResult), .zero(zero)
    );

    // Next PC, no delay slot
    assign pcPlus4 = fetch.pc + 32'd4;
    assign branchTarget = pcPlus4 + (imm << 2);
    assign jumpTarget = {pcPlus4[31:28], jumpIndex, 2'b00};
    assign takeBranch = branch && (zero ^ branchNe);

    always_comb begin
        if (jumpReg)
            fetch.nextPc = da;
        else if (jump)
            fetch.nextPc = jumpTarget;
        else if (takeBranch)
            fetch.nextPc = branchTarget;
        else
            fetch.nextPc = pcPlus4;
    end

    assign wbData = link ? pcPlus4 : (memRead ? mem.rdata : aluResult);

    assign isMem = memRead || memWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            state <= execute;
        else if (state == execute && mem.reqValid)
            state <= waitMem;
        else if (state == waitMem && mem.done)
            state <= execute;
    end

    // Request stays up while the instruction is held
    assign mem.reqValid = fetch.valid && isMem;
    assign mem.we = memWrite;
    assign mem.size = size;
    // lb is the only byte load
    assign mem.signedLoad = 1'b1;
    assign mem.addr = aluResult;
    assign mem.wdata = db;

    assign fetch.done = (state == execute) ? (fetch.valid && !isMem) : mem.done;

    assert property (@(posedge clk) disable iff (!rstN) fetch.done |-> fetch.valid);

endmodule

/* hw/fetchUnit.sv */
`timescale 1ns/1ns

module fetchUnit #(
    parameter coreBusPkg::addrT resetPc = '0
) (
    input  logic clk,
    input  logic rstN,
    fetchIf.fetch fetch,
    output coreBusPkg::addrT iwbAdr,
    input  coreBusPkg::wordT iwbDatI,
    output logic iwbCyc,
    output logic iwbStb,
    input  logic iwbAck
);
    typedef enum logic {busFetch, holdInstr} fetchStateE;

    fetchStateE state;
    coreBusPkg::addrT pc;
    coreBusPkg::wordT instrQ;
    logic cycQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= busFetch;
            pc <= resetPc;
            cycQ <= 1'b0;
        end else begin
            case (state)
                busFetch: begin
                    // First cycle out of reset starts the bus cycle
                    if (!cycQ) begin
                        cycQ <= 1'b1;
                    end else if (iwbAck) begin
                        cycQ <= 1'b0;
                        state <= holdInstr;
                    end
                end
                holdInstr: begin
                    if (fetch.done) begin
                        pc <= fetch.nextPc;
                        cycQ <= 1'b1;
                        state <= busFetch;
                    end
                end
                default: state <= busFetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == busFetch && cycQ && iwbAck)
            instrQ <= iwbDatI;
    end

    assign iwbAdr = pc;
    assign iwbCyc = cycQ;
    assign iwbStb = cycQ;

    assign fetch.valid = (state == holdInstr);
    assign fetch.instr = instrQ;
    assign fetch.pc = pc;

    // Classic cycle ends in the cycle after ack
    assert property (@(posedge clk) disable iff (!rstN) iwbCyc && iwbAck |=> !iwbCyc);

    // Address held through wait states
    assert property (@(posedge clk) disable iff (!rstN)
        iwbStb && !iwbAck |=> $stable(iwbAdr));

    // nextPc from execute must keep the PC aligned
    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

/* hw/instrDecoder.sv */
`timescale 1ns/1ns

module instrDecoder (
    input  coreBusPkg::wordT instr,
    output mipsIsaPkg::regIdxT rs,
    output mipsIsaPkg::regIdxT rt,
    output mipsIsaPkg::regIdxT writeReg,
    output coreBusPkg::wordT imm,
    output logic [25:0] jumpIndex,
    output mipsIsaPkg::aluOpE aluOp,
    output logic aluSrcImm,
    output logic regWrite,
    output logic memRead,
    output logic memWrite,
    output logic branch,
    output logic branchNe,
    output logic jump,
    output logic link,
    output logic jumpReg,
    output coreBusPkg::memSizeE size
);
    mipsIsaPkg::rFieldsT fields;
    mipsIsaPkg::opcodeE opcode;
    mipsIsaPkg::functE funct;
    logic zeroExt;

    assign fields = instr;
    assign opcode = mipsIsaPkg::opcodeE'(fields.opcode);
    assign funct = mipsIsaPkg::functE'(fields.funct);

    assign rs = fields.rs;
    assign rt = fields.rt;
    assign jumpIndex = instr[25:0];
    assign imm = zeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        // Anything not matched below falls through as a nop
        aluOp = mipsIsaPkg::aluAdd;
        aluSrcImm = 1'b1;
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        branch = 1'b0;
        branchNe = 1'b0;
        jump = 1'b0;
        link = 1'b0;
        jumpReg = 1'b0;
        zeroExt = 1'b0;
        size = coreBusPkg::sizeWord;
        writeReg = fields.rt;
        case (opcode)
            mipsIsaPkg::opRtype: begin
                aluSrcImm = 1'b0;
                writeReg = fields.rd;
                regWrite = 1'b1;
                case (funct)
                    mipsIsaPkg::fnAdd, mipsIsaPkg::fnAddu: aluOp = mipsIsaPkg::aluAdd;
                    mipsIsaPkg::fnSub, mipsIsaPkg::fnSubu: aluOp = mipsIsaPkg::aluSub;
                    mipsIsaPkg::fnAnd: aluOp = mipsIsaPkg::aluAnd;
                    mipsIsaPkg::fnOr: aluOp = mipsIsaPkg::aluOr;
                    mipsIsaPkg::fnXor: aluOp = mipsIsaPkg::aluXor;
                    mipsIsaPkg::fnSlt: aluOp = mipsIsaPkg::aluSlt;
                    mipsIsaPkg::fnSll: aluOp = mipsIsaPkg::aluSll;
                    mipsIsaPkg::fnJr: begin
                        jumpReg = 1'b1;
                        regWrite = 1'b0;
                    end
                    default: regWrite = 1'b0;
                endcase
            end
            mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu: regWrite = 1'b1;
            mipsIsaPkg::opSlti: begin
                aluOp = mipsIsaPkg::aluSlt;
                regWrite = 1'b1;
            end
            mipsIsaPkg::opAndi: begin
                aluOp = mipsIsaPkg::aluAnd;
                zeroExt = 1'b1;
                regWrite = 1'b1;
            end
            mipsIsaPkg::opOri: begin
                aluOp = mipsIsaPkg::aluOr;
                zeroExt = 1'b1;
                regWrite = 1'b1;
            end
            mipsIsaPkg::opLui: begin
                aluOp = mipsIsaPkg::aluLui;
                regWrite = 1'b1;
            end
            mipsIsaPkg::opLw, mipsIsaPkg::opLb: begin
                memRead = 1'b1;
                regWrite = 1'b1;
                if (opcode == mipsIsaPkg::opLb)
                    size = coreBusPkg::sizeByte;
            end
            mipsIsaPkg::opSw, mipsIsaPkg::opSb: begin
                memWrite = 1'b1;
                if (opcode == mipsIsaPkg::opSb)
                    size = coreBusPkg::sizeByte;
            end
            mipsIsaPkg::opBeq, mipsIsaPkg::opBne: begin
                // Compare by subtraction, zero flag decides
                aluOp = mipsIsaPkg::aluSub;
                aluSrcImm = 1'b0;
                branch = 1'b1;
                branchNe = (opcode == mipsIsaPkg::opBne);
            end
            mipsIsaPkg::opJ: jump = 1'b1;
            mipsIsaPkg::opJal: begin
                jump = 1'b1;
                link = 1'b1;
                regWrite = 1'b1;
                writeReg = mipsIsaPkg::linkReg;
            end
            default: ;
        endcase
    end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ns

module alu (
    input  coreBusPkg::wordT a,
    input  coreBusPkg::wordT b,
    input  logic [4:0] shamt,
    input  mipsIsaPkg::aluOpE op,
    output coreBusPkg::wordT result,
    output logic zero
);

    always_comb begin
        case (op)
            mipsIsaPkg::aluAdd: result = a + b;
            mipsIsaPkg::aluSub: result = a - b;
            mipsIsaPkg::aluAnd: result = a & b;
            mipsIsaPkg::aluOr: result = a | b;
            mipsIsaPkg::aluXor: result = a ^ b;
            mipsIsaPkg::aluSlt: result = {31'b0, $signed(a) < $signed(b)};
            mipsIsaPkg::aluSll: result = b << shamt;
            mipsIsaPkg::aluLui: result = b << 16;
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic clk,
    input  logic rstN,
    input  mipsIsaPkg::regIdxT ra,
    input  mipsIsaPkg::regIdxT rb,
    input  mipsIsaPkg::regIdxT rw,
    input  logic we,
    input  coreBusPkg::wordT wd,
    output coreBusPkg::wordT da,
    output coreBusPkg::wordT db
);
    coreBusPkg::wordT regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rw != 5'd0) begin
            regs[rw] <= wd;
        end
    end

    // r0 is never written, so it reads as zero
    assign da = regs[ra];
    assign db = regs[rb];

endmodule

/* hw/coreIfs.sv */
`timescale 1ns/1ns

// Instruction handoff between fetch and execute
interface fetchIf;
    logic valid;
    coreBusPkg::wordT instr;
    coreBusPkg::addrT pc;
    logic done;
    coreBusPkg::addrT nextPc;

    modport fetch (
        output valid, instr, pc,
        input  done, nextPc
    );

    modport exec (
        input  valid, instr, pc,
        output done, nextPc
    );
endinterface

// Data access request from execute to the data-bus master
interface memReqIf;
    logic reqValid;
    logic we;
    coreBusPkg::memSizeE size;
    logic signedLoad;
    coreBusPkg::addrT addr;
    coreBusPkg::wordT wdata;
    logic done;
    // Already extended for byte loads
    coreBusPkg::wordT rdata;

    modport req (
        output reqValid, we, size, signedLoad, addr, wdata,
        input  done, rdata
    );

    modport rsp (
        input  reqValid, we, size, signedLoad, addr, wdata,
        output done, rdata
    );
endinterface

/* hw/coreBusPkg.sv */
package coreBusPkg;

    typedef logic [31:0] wordT;

    // Byte address on either bus
    typedef logic [31:0] addrT;

    // One bit per byte lane, lane 0 is bits 7:0
    typedef logic [3:0] selT;

    typedef enum logic {
        sizeByte = 1'b0,
        sizeWord = 1'b1
    } memSizeE;

endpackage

/* hw/mipsIsaPkg.sv */
package mipsIsaPkg;

    typedef logic [4:0] regIdxT;

    // Link register for jal
    localparam regIdxT linkReg = 5'd31;

    // R-type view of an instruction word
    typedef struct packed {
        logic [5:0] opcode;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opAddiu = 6'h09,
        opSlti  = 6'h0a,
        opAndi  = 6'h0c,
        opOri   = 6'h0d,
        opLui   = 6'h0f,
        opLb    = 6'h20,
        opLw    = 6'h23,
        opSb    = 6'h28,
        opSw    = 6'h2b
    } opcodeE;

    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnJr   = 6'h08,
        fnAdd  = 6'h20,
        fnAddu = 6'h21,
        fnSub  = 6'h22,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnSlt  = 6'h2a
    } functE;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluLui
    } aluOpE;

endpackage
